// File: filelist.f
src/tcb_pkg.sv
src/tcb_mem_pkg.sv
src/tcb_mem_storage.sv
src/tcb_mem_port.sv
src/tcb_write_arbiter.sv
src/tcb_mem_top.sv
verif/tcb_mem_clock.sv
verif/tcb_mem_checker.sv
verif/tcb_mem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the multi-port memory testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tcb_mem_tb \
  -f filelist.f \
  -Mdir obj_dir

out=$(./obj_dir/Vtcb_mem_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Regression passed'; then
  exit 0
fi
exit 1

// File: verif/tcb_mem_tb.sv
/* memory testbench
   fill, random and directed traffic against a reference byte model */
module tcb_mem_tb;

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  localparam logic [15:0] SEED        = 16'd54067;
  localparam int unsigned RND_CYC     = 2000;
  // 64 fill cycles, random cycles and margin
  localparam int unsigned CYCLE_LIMIT = 2400;

  ////////////////////
  // signals
  ////////////////////

  logic     tcb;
  logic     reset;
  logic     trn [PORT_NUM];
  logic     wen [PORT_NUM];
  tcb_adr_t adr [PORT_NUM];
  tcb_siz_t siz [PORT_NUM];
  logic     uns [PORT_NUM];
  tcb_dat_t wdt [PORT_NUM];
  tcb_dat_t rdt [PORT_NUM];

  // request for the next cycle
  logic     req_trn [PORT_NUM];
  logic     req_wen [PORT_NUM];
  tcb_adr_t req_adr [PORT_NUM];
  tcb_siz_t req_siz [PORT_NUM];
  logic     req_uns [PORT_NUM];
  tcb_dat_t req_wdt [PORT_NUM];

  // reference model bytes and pending read results
  tcb_byt_t ref_mem  [MEM_SIZ];
  logic     exp_vld  [PORT_NUM][$];
  tcb_dat_t exp_dat  [PORT_NUM][$];
  // last read result expected on rdt
  tcb_dat_t rdt_hold [PORT_NUM];

  logic [15:0] lfsr   = SEED;
  int unsigned cycles = 0;

  tcb_mem_clock clock (.tcb(tcb), .reset(reset));

  tcb_mem_top dut (
    .tcb(tcb), .reset(reset), .trn(trn), .wen(wen), .adr(adr),
    .siz(siz), .uns(uns), .wdt(wdt), .rdt(rdt)
  );

  bind tcb_mem_top tcb_mem_checker chk (
    .tcb(tcb), .reset(reset), .trn(trn), .wen(wen), .siz(siz), .rdt(rdt)
  );

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  // read 2**s bytes from a with wrap at the end of memory and extend
  function automatic tcb_dat_t model_read(tcb_adr_t a, tcb_siz_t s, logic u);
    tcb_dat_t d;
    int       n;
    logic     sgn;
    n = 1 << s;
    d = '0;
    for (int i = 0; i < n; i++) begin
      d[8*i +: 8] = ref_mem[mem_adr_t'((a + i) % MEM_SIZ)];
    end
    sgn = d[8*n-1];
    for (int i = n; i < TCB_BYT_N; i++) begin
      d[8*i +: 8] = u ? 8'h00 : {8{sgn}};
    end
    return d;
  endfunction

  task automatic model_write(tcb_adr_t a, tcb_siz_t s, tcb_dat_t w);
    for (int i = 0; i < (1 << s); i++) begin
      ref_mem[mem_adr_t'((a + i) % MEM_SIZ)] = w[8*i +: 8];
    end
  endtask

  task automatic report_failure(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  // retire reads that reached the output and compare every port
  task automatic check_outputs();
    logic     vld;
    tcb_dat_t dat;
    for (int p = 0; p < PORT_NUM; p++) begin
      if (exp_vld[p].size() == RDT_DLY) begin
        vld = exp_vld[p].pop_front();
        dat = exp_dat[p].pop_front();
        if (vld) begin
          rdt_hold[p] = dat;
        end
      end
      assert (rdt[p] === rdt_hold[p]) else begin
        report_failure($sformatf("mismatch time=%0t signal=rdt[%0d] expected=%08h actual=%08h",
                                 $time, p, rdt_hold[p], rdt[p]));
      end
    end
  endtask

  task automatic clear_requests();
    for (int p = 0; p < PORT_NUM; p++) begin
      req_trn[p] = 1'b0;
      req_wen[p] = 1'b0;
      req_adr[p] = '0;
      req_siz[p] = '0;
      req_uns[p] = 1'b0;
      req_wdt[p] = '0;
    end
  endtask

  task automatic set_request(int p, logic w, tcb_adr_t a, tcb_siz_t s, logic u, tcb_dat_t d);
    req_trn[p] = 1'b1;
    req_wen[p] = w;
    req_adr[p] = a;
    req_siz[p] = s;
    req_uns[p] = u;
    req_wdt[p] = d;
  endtask

  task automatic random_request(int p);
    tcb_adr_t a;
    tcb_siz_t s;
    req_trn[p] = 1'(random_bits(1));
    req_wen[p] = 1'(random_bits(1));
    s = tcb_siz_t'(random_bits(2));
    if (s == 2'd3) begin
      s = 2'd0;
    end
    req_siz[p] = s;
    req_uns[p] = 1'(random_bits(1));
    a = random_bits(32);
    // crowd both ports near the end to force wraps and overlaps
    if (random_bits(1) != 0) begin
      a[$bits(mem_adr_t)-1:0] = mem_adr_t'(MEM_SIZ - 8) | mem_adr_t'(random_bits(3));
    end
    req_adr[p] = a;
    req_wdt[p] = random_bits(32);
  endtask

  // called on a falling edge and returns on the next one
  task automatic run_cycle();
    check_outputs();
    for (int p = 0; p < PORT_NUM; p++) begin
      trn[p] = req_trn[p];
      wen[p] = req_wen[p];
      adr[p] = req_adr[p];
      siz[p] = req_siz[p];
      uns[p] = req_uns[p];
      wdt[p] = req_wdt[p];
      exp_vld[p].push_back(req_trn[p] && !req_wen[p]);
      exp_dat[p].push_back(model_read(req_adr[p], req_siz[p], req_uns[p]));
    end
    // reads above saw the old bytes
    // writes go in port order so port 1 wins
    for (int p = 0; p < PORT_NUM; p++) begin
      if (req_trn[p] && req_wen[p]) begin
        model_write(req_adr[p], req_siz[p], req_wdt[p]);
      end
    end
    @(negedge tcb);
  endtask

  ////////////////////
  // directed cases
  ////////////////////

  task automatic directed_cases();
    // word across the end of memory with upper address bits set
    clear_requests();
    set_request(0, 1'b1, 32'h1000_00fe, 2'd2, 1'b0, random_bits(32));
    run_cycle();
    clear_requests();
    set_request(0, 1'b0, 32'h0000_00fe, 2'd2, 1'b1, '0);
    set_request(1, 1'b0, 32'h0000_00ff, 2'd1, 1'b0, '0);
    run_cycle();
    // overlapping writes where port 1 owns bytes 0x41 and 0x42
    clear_requests();
    set_request(0, 1'b1, 32'h40, 2'd2, 1'b0, random_bits(32));
    set_request(1, 1'b1, 32'h41, 2'd1, 1'b0, random_bits(32));
    run_cycle();
    clear_requests();
    set_request(0, 1'b0, 32'h40, 2'd2, 1'b0, '0);
    set_request(1, 1'b0, 32'h3f, 2'd2, 1'b0, '0);
    run_cycle();
    // port 1 reads the old word while port 0 writes it
    clear_requests();
    set_request(0, 1'b1, 32'h80, 2'd2, 1'b0, random_bits(32));
    set_request(1, 1'b0, 32'h80, 2'd2, 1'b0, '0);
    run_cycle();
    // new word visible one cycle later to the writing port too
    clear_requests();
    set_request(0, 1'b0, 32'h80, 2'd2, 1'b0, '0);
    set_request(1, 1'b0, 32'h83, 2'd0, 1'b0, '0);
    run_cycle();
    // idle and write-only cycles keep rdt
    clear_requests();
    run_cycle();
    set_request(1, 1'b1, 32'h90, 2'd0, 1'b0, random_bits(32));
    run_cycle();
    clear_requests();
    repeat (RDT_DLY + 2) begin
      run_cycle();
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    clear_requests();
    for (int p = 0; p < PORT_NUM; p++) begin
      trn[p] = 1'b0;
      wen[p] = 1'b0;
      adr[p] = '0;
      siz[p] = '0;
      uns[p] = 1'b0;
      wdt[p] = '0;
      rdt_hold[p] = '0;
    end
    while (reset !== 1'b0) @(posedge tcb);
    @(negedge tcb);
    // fill every aligned word from port 0
    for (int w = 0; w < MEM_SIZ / TCB_BYT_N; w++) begin
      clear_requests();
      set_request(0, 1'b1, tcb_adr_t'(TCB_BYT_N * w), 2'd2, 1'b0, random_bits(32));
      run_cycle();
    end
    // both ports read all words in different orders
    for (int w = 0; w < MEM_SIZ / TCB_BYT_N; w++) begin
      for (int p = 0; p < PORT_NUM; p++) begin
        set_request(p, 1'b0, tcb_adr_t'(TCB_BYT_N * ((w + 16 * p) % (MEM_SIZ / TCB_BYT_N))),
                    2'd2, 1'(random_bits(1)), '0);
      end
      run_cycle();
    end
    repeat (RND_CYC) begin
      for (int p = 0; p < PORT_NUM; p++) begin
        random_request(p);
      end
      run_cycle();
    end
    directed_cases();
    $display("Regression passed");
    $finish;
  end

  // run limit
  always @(posedge tcb) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      report_failure($sformatf("timeout, tests did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

endmodule: tcb_mem_tb

// File: verif/tcb_mem_checker.sv
/* bound assertions on the memory top level
   legal transfer size, read data hold and known read data */
module tcb_mem_checker (
  input logic              tcb,
  input logic              reset,
  input logic              trn [tcb_mem_pkg::PORT_NUM],
  input logic              wen [tcb_mem_pkg::PORT_NUM],
  input tcb_pkg::tcb_siz_t siz [tcb_mem_pkg::PORT_NUM],
  input tcb_pkg::tcb_dat_t rdt [tcb_mem_pkg::PORT_NUM]
);

  import tcb_mem_pkg::*;

  ////////////////////
  // per-port properties
  ////////////////////

  for (genvar p = 0; p < PORT_NUM; p++) begin: gen_chk

    // size 3 has no byte count
    siz_legal: assert property (
      @(posedge tcb) disable iff (reset)
      trn[p] |-> (siz[p] != 2'd3)
    ) else $error("port %0d started a transfer with illegal size 3", p);

    // no read, so the output register keeps its value
    rdt_hold: assert property (
      @(posedge tcb) disable iff (reset)
      !(trn[p] && !wen[p]) |-> ##(RDT_DLY) $stable(rdt[p])
    ) else $error("port %0d read data changed after a cycle without a read", p);

    // a read result must be fully known once it arrives
    rdt_known: assert property (
      @(posedge tcb) disable iff (reset)
      (trn[p] && !wen[p]) |-> ##(RDT_DLY) !$isunknown(rdt[p])
    ) else $error("port %0d read data has unknown bits after a read", p);

  end: gen_chk

endmodule: tcb_mem_checker

// File: verif/tcb_mem_clock.sv
/* testbench clock and reset generator */
module tcb_mem_clock (
  output logic tcb,
  output logic reset
);

  // clock period in time units
  localparam int unsigned PERIOD  = 40;
  // reset length in clock cycles
  localparam int unsigned RST_CYC = 16;

  initial begin
    tcb = 1'b0;
    forever #(PERIOD/2) tcb = ~tcb;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (RST_CYC) @(posedge tcb);
    @(negedge tcb);
    reset = 1'b0;
  end

endmodule: tcb_mem_clock

// File: src/tcb_mem_top.sv
/* multi-port memory top level
   loose per-port bus signals, storage, port blocks and write arbiter */
module tcb_mem_top (
  // system clock and synchronous reset
  input  logic              tcb,
  input  logic              reset,
  // per-port bus request
  input  logic              trn [tcb_mem_pkg::PORT_NUM],
  input  logic              wen [tcb_mem_pkg::PORT_NUM],
  input  tcb_pkg::tcb_adr_t adr [tcb_mem_pkg::PORT_NUM],
  input  tcb_pkg::tcb_siz_t siz [tcb_mem_pkg::PORT_NUM],
  input  logic              uns [tcb_mem_pkg::PORT_NUM],
  input  tcb_pkg::tcb_dat_t wdt [tcb_mem_pkg::PORT_NUM],
  // per-port bus response
  output tcb_pkg::tcb_dat_t rdt [tcb_mem_pkg::PORT_NUM]
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////
  // local signals
  ////////////////////

  // port lanes, also the storage read indices
  lane_adr_t            lane_adr [PORT_NUM];
  logic [TCB_BYT_N-1:0] lane_wen [PORT_NUM];
  lane_byt_t            lane_byt [PORT_NUM];

  // storage read lanes back to the ports
  lane_byt_t            lane_rdt [PORT_NUM];

  // committed writes
  logic [TCB_BYT_N-1:0] wr_en  [PORT_NUM];
  lane_adr_t            wr_adr [PORT_NUM];
  lane_byt_t            wr_byt [PORT_NUM];

  ////////////////////
  // storage
  ////////////////////

  tcb_mem_storage storage (
    .tcb    (tcb),
    .rd_adr (lane_adr),
    .rd_byt (lane_rdt),
    .wr_en  (wr_en),
    .wr_adr (wr_adr),
    .wr_byt (wr_byt)
  );

  ////////////////////
  // ports
  ////////////////////

  for (genvar p = 0; p < PORT_NUM; p++) begin: gen_port
    tcb_mem_port port (
      .tcb      (tcb),
      .reset    (reset),
      .trn      (trn[p]),
      .wen      (wen[p]),
      .adr      (adr[p]),
      .siz      (siz[p]),
      .uns      (uns[p]),
      .wdt      (wdt[p]),
      .rd_byt   (lane_rdt[p]),
      .lane_adr (lane_adr[p]),
      .lane_wen (lane_wen[p]),
      .lane_byt (lane_byt[p]),
      .rdt      (rdt[p])
    );
  end: gen_port

  ////////////////////
  // write arbiter
  ////////////////////

  // same-byte writes go to the highest port index
  tcb_write_arbiter arbiter (
    .lane_wen (lane_wen),
    .lane_adr (lane_adr),
    .lane_byt (lane_byt),
    .wr_en    (wr_en),
    .wr_adr   (wr_adr),
    .wr_byt   (wr_byt)
  );

endmodule: tcb_mem_top

// File: src/tcb_write_arbiter.sv
/* write arbiter
   resolves same-byte writes across ports, higher port index wins */
module tcb_write_arbiter (
  // write lanes from the ports
  input  logic [tcb_pkg::TCB_BYT_N-1:0] lane_wen [tcb_mem_pkg::PORT_NUM],
  input  tcb_mem_pkg::lane_adr_t        lane_adr [tcb_mem_pkg::PORT_NUM],
  input  tcb_mem_pkg::lane_byt_t        lane_byt [tcb_mem_pkg::PORT_NUM],
  // committed write lanes toward storage
  output logic [tcb_pkg::TCB_BYT_N-1:0] wr_en [tcb_mem_pkg::PORT_NUM],
  output tcb_mem_pkg::lane_adr_t        wr_adr [tcb_mem_pkg::PORT_NUM],
  output tcb_mem_pkg::lane_byt_t        wr_byt [tcb_mem_pkg::PORT_NUM]
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////
  // conflict check
  ////////////////////

  // a lane loses when a higher port writes the same index this cycle
  // lanes inside one port are consecutive indices and never collide,
  // so only higher ports are searched
  always_comb begin
    for (int p = 0; p < PORT_NUM; p++) begin
      for (int l = 0; l < TCB_BYT_N; l++) begin
        // start from the port's own strobe
        wr_en[p][l] = lane_wen[p][l];
        for (int q = p + 1; q < PORT_NUM; q++) begin
          for (int m = 0; m < TCB_BYT_N; m++) begin
            if (lane_wen[q][m] && (lane_adr[q][m] == lane_adr[p][l])) begin
              wr_en[p][l] = 1'b0;
            end
          end
        end
      end
    end
  end

  ////////////////////
  // lane payload
  ////////////////////

  // index and byte go to storage unchanged, only the strobe is filtered
  always_comb begin
    for (int p = 0; p < PORT_NUM; p++) begin
      wr_adr[p] = lane_adr[p];
      wr_byt[p] = lane_byt[p];
    end
  end

endmodule: tcb_write_arbiter

// File: src/tcb_mem_port.sv
/* single memory port
   lane decoding, write lanes, read extension and read delay pipeline */
module tcb_mem_port (
  // system clock and synchronous reset
  input  logic                          tcb,
  input  logic                          reset,
  // bus request
  input  logic                          trn,
  input  logic                          wen,
  input  tcb_pkg::tcb_adr_t             adr,
  input  tcb_pkg::tcb_siz_t             siz,
  input  logic                          uns,
  input  tcb_pkg::tcb_dat_t             wdt,
  // storage read lanes
  input  tcb_mem_pkg::lane_byt_t        rd_byt,
  // lane indices, shared by the read and the write path
  output tcb_mem_pkg::lane_adr_t        lane_adr,
  // write lanes toward the arbiter
  output logic [tcb_pkg::TCB_BYT_N-1:0] lane_wen,
  output tcb_mem_pkg::lane_byt_t        lane_byt,
  // bus response
  output tcb_pkg::tcb_dat_t             rdt
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////
  // lane decoding
  ////////////////////

  // lanes covered by the transfer size
  logic [TCB_BYT_N-1:0] lane_val;

  // read request in this cycle
  logic rd_req;

  // byte indices of consecutive lanes
  // the sum is kept to the index width, which gives the wrap
  always_comb begin
    for (int l = 0; l < TCB_BYT_N; l++) begin
      lane_adr[l] = mem_adr_t'(adr) + mem_adr_t'(l);
    end
  end

  // byte count is 2**siz, lane 0 always inside
  always_comb begin
    for (int l = 0; l < TCB_BYT_N; l++) begin
      lane_val[l] = (l < (1 << siz));
    end
  end

  assign rd_req = trn & ~wen;

  ////////////////////
  // write lanes
  ////////////////////

  // strobe only the lanes inside the byte count
  assign lane_wen = {TCB_BYT_N{trn & wen}} & lane_val;

  // write byte 0 sits in lane 0, same order as the lane indices
  assign lane_byt = wdt;

  ////////////////////
  // read extension
  ////////////////////

  // msb of the last transferred byte
  logic     rd_sgn;
  // extended read result
  tcb_dat_t rd_ext;

  // the highest valid lane wins
  always_comb begin
    rd_sgn = 1'b0;
    for (int l = 0; l < TCB_BYT_N; l++) begin
      if (lane_val[l]) begin
        rd_sgn = rd_byt[l][$bits(tcb_byt_t)-1];
      end
    end
  end

  // lanes past the byte count repeat the sign, or zero on unsigned reads
  always_comb begin
    for (int l = 0; l < TCB_BYT_N; l++) begin
      if (lane_val[l]) begin
        rd_ext[l*$bits(tcb_byt_t)+:$bits(tcb_byt_t)] = rd_byt[l];
      end else begin
        rd_ext[l*$bits(tcb_byt_t)+:$bits(tcb_byt_t)] = {$bits(tcb_byt_t){rd_sgn & ~uns}};
      end
    end
  end

  ////////////////////
  // read delay
  ////////////////////

  // stage 0 is the current request, later stages are registers
  for (genvar d = 0; d < RDT_DLY; d++) begin: gen_stg
    logic     vld;
    tcb_dat_t dat;
    if (d == 0) begin: gen_in
      assign vld = rd_req;
      assign dat = rd_ext;
    end else begin: gen_reg
      // valid flag follows the read
      always_ff @(posedge tcb) begin
        if (reset) begin
          vld <= 1'b0;
        end else begin
          vld <= gen_stg[d-1].vld;
        end
      end
      // data moves only with a valid read
      always_ff @(posedge tcb) begin
        if (gen_stg[d-1].vld) begin
          dat <= gen_stg[d-1].dat;
        end
      end
    end
  end: gen_stg

  // output register
  // holds the last read result through idle and write cycles
  always_ff @(posedge tcb) begin
    if (reset) begin
      rdt <= '0;
    end else if (gen_stg[RDT_DLY-1].vld) begin
      rdt <= gen_stg[RDT_DLY-1].dat;
    end
  end

endmodule: tcb_mem_port

// File: src/tcb_mem_storage.sv
/* byte storage array
   combinational read lanes per port, clocked write lanes per port */
module tcb_mem_storage (
  // system clock
  input  logic                         tcb,
  // read lanes, one index per byte lane
  input  tcb_mem_pkg::lane_adr_t       rd_adr [tcb_mem_pkg::PORT_NUM],
  output tcb_mem_pkg::lane_byt_t       rd_byt [tcb_mem_pkg::PORT_NUM],
  // committed write lanes from the arbiter
  input  logic [tcb_pkg::TCB_BYT_N-1:0] wr_en [tcb_mem_pkg::PORT_NUM],
  input  tcb_mem_pkg::lane_adr_t       wr_adr [tcb_mem_pkg::PORT_NUM],
  input  tcb_mem_pkg::lane_byt_t       wr_byt [tcb_mem_pkg::PORT_NUM]
);

  import tcb_pkg::*;
  import tcb_mem_pkg::*;

  ////////////////////
  // storage array
  ////////////////////

  // one byte per entry
  // contents survive reset
  tcb_byt_t mem [MEM_SIZ];

  ////////////////////
  // read lanes
  ////////////////////

  // asynchronous read, one byte per lane per port
  // old contents are seen in a cycle that also writes the same byte
  always_comb begin
    for (int p = 0; p < PORT_NUM; p++) begin
      for (int l = 0; l < TCB_BYT_N; l++) begin
        rd_byt[p][l] = mem[rd_adr[p][l]];
      end
    end
  end

  ////////////////////
  // write lanes
  ////////////////////

  // every committed lane is written at the same edge
  // the arbiter leaves at most one committed lane per index,
  // so the loop order never decides the stored value
  always_ff @(posedge tcb) begin
    for (int p = 0; p < PORT_NUM; p++) begin
      for (int l = 0; l < TCB_BYT_N; l++) begin
        if (wr_en[p][l]) begin
          mem[wr_adr[p][l]] <= wr_byt[p][l];
        end
      end
    end
  end

endmodule: tcb_mem_storage

// File: src/tcb_mem_pkg.sv
/* memory configuration package
   size, port count, read delay and storage index types */
package tcb_mem_pkg;

  ////////////////////
  // configuration
  ////////////////////

  // memory size in bytes, power of two
  localparam int unsigned MEM_SIZ = 256;

  // number of bus ports
  localparam int unsigned PORT_NUM = 2;

  // read data delay in clock cycles, at least 1
  localparam int unsigned RDT_DLY = 1;

  ////////////////////
  // storage types
  ////////////////////

  // byte index into storage
  // low address bits only, so accesses past the end wrap to 0
  typedef logic [$clog2(MEM_SIZ)-1:0] mem_adr_t;

  // one storage index per byte lane of a port
  typedef mem_adr_t [tcb_pkg::TCB_BYT_N-1:0] lane_adr_t;

  // one byte per byte lane of a port
  typedef tcb_pkg::tcb_byt_t [tcb_pkg::TCB_BYT_N-1:0] lane_byt_t;

endpackage: tcb_mem_pkg

// File: src/tcb_pkg.sv
/* tightly coupled bus package
   address, data, byte and transfer size types */
package tcb_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  // byte address width
  localparam int unsigned TCB_ADR_W = 32;

  // byte lanes on the data bus
  localparam int unsigned TCB_BYT_N = 4;

  ////////////////////
  // bus vector types
  ////////////////////

  // byte address, any alignment allowed
  typedef logic [TCB_ADR_W-1:0] tcb_adr_t;

  // one byte lane
  typedef logic [8-1:0] tcb_byt_t;

  // read/write data, lane 0 holds the byte at the start address
  typedef logic [TCB_BYT_N*8-1:0] tcb_dat_t;

  // transfer size as log2 of byte count
  // 0 byte, 1 half, 2 word
  // 3 is not a legal transfer size
  typedef logic [2-1:0] tcb_siz_t;

endpackage: tcb_pkg
